// File: design/sprite.sv
/*
  one sprite renderer, 16 pattern bits per row, 8-wide sprites leave the low byte 0
  one VDP pixel is two pxclk cycles, mag doubles that
  nothing shows before the first vdp_col0_tick after a load
*/
`timescale 1ns/1ns

module sprite (
    input  logic                  pxclk,
    input  logic                  reset,
    input  logic                  vdp_col0_tick,
    input  logic                  load_tick,
    input  vdp_pkg::sprite_attr_t attr,
    output vdp_pkg::color_t       color_out
);

    logic            active_reg;    // rendering has started for this line
    logic [1:0]      phase_reg;     // pxclk count since column 0, modulo 4
    logic            mag_reg;
    logic [8:0]      hpos_reg;      // VDP pixels left before the first bit
    logic [15:0]     pattern_reg;   // bit 15 is the bit on screen
    vdp_pkg::color_t fg_color_reg;
    logic            vdp_step;      // last pxclk of a VDP pixel
    logic            shift_en;

    // odd phase ends a VDP pixel
    assign vdp_step = active_reg && phase_reg[0];

    // magnified rows move only every second VDP pixel, on phase 3
    assign shift_en = vdp_step && (hpos_reg == 9'd0) && (!mag_reg || phase_reg == 2'd3);

    // ******************************
    // line control
    // ******************************
    always_ff @(posedge pxclk) begin
        if (reset) begin
            active_reg <= 1'b0;
            phase_reg  <= 2'd0;
        end else begin
            if (vdp_col0_tick) begin
                active_reg <= 1'b1;
                phase_reg  <= 2'd0;             // jam sync so column 0 starts at phase 0
            end else begin
                if (load_tick) begin
                    active_reg <= 1'b0;         // wait for the next column 0
                end
                phase_reg <= phase_reg + 2'd1;
            end
        end
    end

    // the pattern starts empty so an unloaded sprite shows nothing
    always_ff @(posedge pxclk) begin
        if (reset) begin
            pattern_reg <= '0;
        end else if (load_tick) begin
            pattern_reg <= attr.pattern;
        end else if (shift_en) begin
            pattern_reg <= {pattern_reg[14:0], 1'b0};   // next bit to the top
        end
    end

    // ******************************
    // position and colour
    // ******************************
    always_ff @(posedge pxclk) begin
        if (load_tick) begin
            mag_reg      <= attr.mag;
            hpos_reg     <= attr.hpos;
            fg_color_reg <= attr.fg_color;
        end else if (vdp_step && hpos_reg != 9'd0) begin
            hpos_reg <= hpos_reg - 9'd1;    // one per VDP pixel until the left edge
        end
    end

    // once the pattern has shifted out it is all zero and the sprite goes quiet
    assign color_out = (active_reg && hpos_reg == 9'd0 && pattern_reg[15]) ? fg_color_reg : '0;

endmodule

// File: design/sprite_config.svh
/*
  build-time sizes for the sprite line engine
  SPRITE_COUNT sets the renderer count and the words read per line
  WB_DATA_BITS must stay 32 since one bus word carries one attribute word
*/
`ifndef SPRITE_CONFIG_SVH
`define SPRITE_CONFIG_SVH

// number of sprite renderers, one attribute word each
`define SPRITE_COUNT 4

// Wishbone classic port widths
`define WB_ADDR_BITS 16
`define WB_DATA_BITS 32

// backdrop colour shown on pixel while reset is held
`define BACKDROP_RESET 4'd0

`endif

// File: design/sprite_line_engine.sv
/*
  scan-line sprite engine, loader plus SPRITE_COUNT renderers plus priority mux
  pixel trails the renderer colours by one pxclk
  the sprite memory must hold SPRITE_COUNT words from line_base onward
*/
`timescale 1ns/1ns
`include "sprite_config.svh"

module sprite_line_engine (
    input  logic                     pxclk,
    input  logic                     reset,
    input  logic                     line_start,
    input  logic [`WB_ADDR_BITS-1:0] line_base,
    input  logic                     vdp_col0_tick,
    input  vdp_pkg::color_t          backdrop,
    input  wb_pkg::wb_rsp_t          bus_rsp,
    output wb_pkg::wb_req_t          bus_req,
    output vdp_pkg::color_t          pixel,
    output logic                     collision,
    output logic                     fetch_late
);

    logic                  load_tick;                  // shared by all renderers
    vdp_pkg::sprite_attr_t attrs  [`SPRITE_COUNT];     // one word per renderer
    vdp_pkg::color_t       colors [`SPRITE_COUNT];     // renderer outputs, 0 = clear

    // ******************************
    // attribute fetch
    // ******************************
    sprite_row_loader i_loader (
        .pxclk         (pxclk),
        .reset         (reset),
        .line_start    (line_start),
        .line_base     (line_base),
        .vdp_col0_tick (vdp_col0_tick),
        .bus_rsp       (bus_rsp),
        .bus_req       (bus_req),
        .load_tick     (load_tick),
        .attrs         (attrs),
        .fetch_late    (fetch_late)
    );

    // ******************************
    // renderers
    // ******************************
    genvar g;
    generate
        for (g = 0; g < `SPRITE_COUNT; g++) begin : g_sprite
            sprite i_sprite (
                .pxclk         (pxclk),
                .reset         (reset),
                .vdp_col0_tick (vdp_col0_tick),
                .load_tick     (load_tick),
                .attr          (attrs[g]),
                .color_out     (colors[g])
            );
        end
    endgenerate

    // index 0 has the highest priority
    sprite_priority_mux i_mux (
        .pxclk      (pxclk),
        .reset      (reset),
        .line_start (line_start),
        .colors     (colors),
        .backdrop   (backdrop),
        .pixel      (pixel),
        .collision  (collision)
    );

endmodule

// File: design/sprite_priority_mux.sv
/*
  lowest sprite index wins, backdrop where every sprite is transparent
  collision needs two nonzero colours in the same cycle and holds until line_start
*/
`timescale 1ns/1ns
`include "sprite_config.svh"

module sprite_priority_mux (
    input  logic            pxclk,
    input  logic            reset,
    input  logic            line_start,
    input  vdp_pkg::color_t colors [`SPRITE_COUNT],
    input  vdp_pkg::color_t backdrop,
    output vdp_pkg::color_t pixel,
    output logic            collision
);

    vdp_pkg::color_t winner;        // colour of the lowest opaque sprite
    logic            any_opaque;
    logic            multi_opaque;  // a second opaque sprite was seen

    always_comb begin
        winner       = '0;
        any_opaque   = 1'b0;
        multi_opaque = 1'b0;
        for (int i = 0; i < `SPRITE_COUNT; i++) begin
            if (colors[i] != '0) begin
                if (any_opaque) begin
                    multi_opaque = 1'b1;    // higher index loses but still collides
                end else begin
                    winner     = colors[i];
                    any_opaque = 1'b1;
                end
            end
        end
    end

    always_ff @(posedge pxclk) begin
        if (reset) begin
            pixel     <= `BACKDROP_RESET;
            collision <= 1'b0;
        end else begin
            pixel <= any_opaque ? winner : backdrop;
            if (line_start) begin
                collision <= 1'b0;          // new line, new collision window
            end else if (multi_opaque) begin
                collision <= 1'b1;
            end
        end
    end

    // every renderer and the backdrop must resolve to a known colour
    a_pixel_known: assert property (@(posedge pxclk) disable iff (reset)
        !$isunknown(pixel));

endmodule

// File: design/sprite_row_loader.sv
/*
  fetches SPRITE_COUNT attribute words per line, in index order, from line_base
  line_start is only taken while idle
  when vdp_col0_tick lands mid fetch the line is dropped and fetch_late is set
*/
`timescale 1ns/1ns
`include "sprite_config.svh"

module sprite_row_loader (
    input  logic                     pxclk,
    input  logic                     reset,
    input  logic                     line_start,
    input  logic [`WB_ADDR_BITS-1:0] line_base,
    input  logic                     vdp_col0_tick,
    input  wb_pkg::wb_rsp_t          bus_rsp,
    output wb_pkg::wb_req_t          bus_req,
    output logic                     load_tick,
    output vdp_pkg::sprite_attr_t    attrs [`SPRITE_COUNT],
    output logic                     fetch_late
);

    localparam int ADDR_BITS = `WB_ADDR_BITS;
    localparam int IDX_BITS = (`SPRITE_COUNT > 1) ? $clog2(`SPRITE_COUNT) : 1;
    localparam logic [IDX_BITS-1:0] LAST_IDX = IDX_BITS'(`SPRITE_COUNT - 1);

    vdp_pkg::loader_state_t state;
    logic [IDX_BITS-1:0]    idx;        // sprite whose word is being read
    logic [ADDR_BITS-1:0]   base_reg;   // line_base captured at line_start
    logic                   cyc_reg;
    logic                   stb_reg;
    logic [ADDR_BITS-1:0]   adr_reg;
    vdp_pkg::sprite_attr_t  rd_attr;    // ack data with the enable mask applied
    logic                   busy;       // a read sequence is in flight
    logic                   late_now;   // fetch_late including this cycle's tick

    assign busy = (state == vdp_pkg::fetch) || (state == vdp_pkg::wait_ack);
    assign late_now = fetch_late || (vdp_col0_tick && busy);

    always_comb begin
        bus_req.cyc = cyc_reg;
        bus_req.stb = stb_reg;
        bus_req.we  = 1'b0;     // never writes
        bus_req.adr = adr_reg;
    end

    // a disabled sprite keeps its word but renders an empty row
    always_comb begin
        rd_attr = vdp_pkg::sprite_attr_t'(bus_rsp.dat);
        if (!rd_attr.enable) begin
            rd_attr.pattern = '0;
        end
    end

    // ******************************
    // fetch sequencer
    // ******************************
    always_ff @(posedge pxclk) begin
        if (reset) begin
            state      <= vdp_pkg::idle;
            idx        <= '0;
            cyc_reg    <= 1'b0;
            stb_reg    <= 1'b0;
            load_tick  <= 1'b0;
            fetch_late <= 1'b0;
        end else begin
            load_tick  <= 1'b0;                         // only ever a single pulse
            fetch_late <= line_start ? 1'b0 : late_now; // sticky for the rest of the line
            case (state)
                vdp_pkg::idle: begin
                    if (line_start) begin
                        idx   <= '0;
                        state <= vdp_pkg::fetch;
                    end
                end
                vdp_pkg::fetch: begin
                    cyc_reg <= 1'b1;    // first read raises cyc and stb together
                    stb_reg <= 1'b1;
                    state   <= vdp_pkg::wait_ack;
                end
                vdp_pkg::wait_ack: begin
                    if (bus_rsp.ack) begin
                        stb_reg <= 1'b0;    // gap of one cycle before the next beat
                        if (idx == LAST_IDX) begin
                            cyc_reg   <= 1'b0;
                            load_tick <= !late_now; // a late line never reaches the sprites
                            state     <= vdp_pkg::done;
                        end else begin
                            idx   <= idx + 1'b1;
                            state <= vdp_pkg::fetch;
                        end
                    end
                end
                vdp_pkg::done: begin
                    state <= vdp_pkg::idle;
                end
                default: begin
                    state <= vdp_pkg::idle;
                end
            endcase
        end
    end

    // ******************************
    // address and shadow words
    // ******************************
    always_ff @(posedge pxclk) begin
        if (state == vdp_pkg::idle && line_start) begin
            base_reg <= line_base;
        end
        if (state == vdp_pkg::fetch) begin
            adr_reg <= base_reg + ADDR_BITS'(idx);  // word address of sprite idx
        end
        if (state == vdp_pkg::wait_ack && bus_rsp.ack) begin
            attrs[idx] <= rd_attr;  // sprites only see it at load_tick
        end
    end

    // classic handshake, stb is only meaningful inside a cycle
    a_stb_in_cyc: assert property (@(posedge pxclk) disable iff (reset)
        bus_req.stb |-> bus_req.cyc);

    // every renderer latches exactly once per line
    a_load_single: assert property (@(posedge pxclk) disable iff (reset)
        load_tick |=> !load_tick);

endmodule

// File: design/vdp_pkg.sv
/*
  video side types of the sprite engine
  colour index 0 is transparent everywhere in the design
*/
package vdp_pkg;

    // 4-bit palette index
    typedef logic [3:0] color_t;

    // ******************************
    // one sprite row as read from sprite memory, 32 bits, msb first
    // ******************************
    typedef struct packed {
        logic        enable;    // 0 blanks the sprite for this line
        logic        mag;       // 1 doubles each pattern bit to two VDP pixels
        color_t      fg_color;  // colour for the set pattern bits
        logic [8:0]  hpos;      // left edge in VDP pixels from column 0
        logic        spare;     // no function, read back as stored
        logic [15:0] pattern;   // row pattern, bit 15 is leftmost
    } sprite_attr_t;

    // attribute fetch sequence of the row loader
    typedef enum logic [1:0] {
        idle     = 2'd0,  // waiting for line_start
        fetch    = 2'd1,  // stb low for one cycle, next read set up
        wait_ack = 2'd2,  // cyc and stb high until the slave acks
        done     = 2'd3   // load_tick cycle after the last ack
    } loader_state_t;

endpackage

// File: design/wb_pkg.sv
/*
  Wishbone classic signal bundles for the sprite memory port
  read only, no sel, no burst tags, no err or rty
*/
`include "sprite_config.svh"

package wb_pkg;

    // ******************************
    // master to slave
    // ******************************
    typedef struct packed {
        logic                     cyc;  // bus cycle in progress
        logic                     stb;  // this beat is valid
        logic                     we;   // always 0 here, the engine only reads
        logic [`WB_ADDR_BITS-1:0] adr;  // word address
    } wb_req_t;

    // ******************************
    // slave to master
    // ******************************
    typedef struct packed {
        logic [`WB_DATA_BITS-1:0] dat;  // valid only while ack is high
        logic                     ack;  // one cycle per accepted beat
    } wb_rsp_t;

endpackage

// File: src.f
+incdir+design
design/vdp_pkg.sv
design/wb_pkg.sv
design/sprite_row_loader.sv
design/sprite.sv
design/sprite_priority_mux.sv
design/sprite_line_engine.sv
verif/sprite_mem_model.sv
verif/tb_sprite_line.sv

// File: verif/sprite_mem_model.sv
/*
  Wishbone classic read slave for simulation, one 32-bit word per address
  ack comes ack_delay+1 cycles after a beat opens, ack_delay is sampled at that point
  contents change only through the load port, bus writes are ignored
*/
`timescale 1ns/1ns
`include "sprite_config.svh"

module sprite_mem_model (
    input  logic                     pxclk,
    input  logic                     reset,
    input  logic [2:0]               ack_delay,
    input  logic                     ld_en,
    input  logic [`WB_ADDR_BITS-1:0] ld_adr,
    input  logic [`WB_DATA_BITS-1:0] ld_dat,
    input  wb_pkg::wb_req_t          bus_req,
    output wb_pkg::wb_rsp_t          bus_rsp
);

    localparam int DEPTH = 2 ** `WB_ADDR_BITS;

    logic [`WB_DATA_BITS-1:0] mem [DEPTH];
    logic [2:0]               wait_cnt;     // cycles still to go before ack
    logic                     counting;     // a delayed beat is in progress
    logic                     beat_open;

    // a beat is open from stb until the ack cycle
    assign beat_open = bus_req.cyc && bus_req.stb && !bus_rsp.ack;

    // every word differs so a wrong address shows up as wrong data
    initial begin
        for (int a = 0; a < DEPTH; a++) begin
            mem[a] = {~16'(a), 16'(a)};
        end
    end

    always @(posedge pxclk) begin
        if (ld_en) begin
            mem[ld_adr] <= ld_dat;  // testbench preload of the attribute table
        end
    end

    // ******************************
    // ack with variable delay
    // ******************************
    always_ff @(posedge pxclk) begin
        if (reset) begin
            bus_rsp  <= '0;
            counting <= 1'b0;
            wait_cnt <= '0;
        end else begin
            bus_rsp.ack <= 1'b0;                    // ack lasts a single cycle
            if (beat_open) begin
                if (counting ? (wait_cnt == 3'd0) : (ack_delay == 3'd0)) begin
                    bus_rsp.ack <= 1'b1;
                    bus_rsp.dat <= mem[bus_req.adr];    // data valid with ack
                    counting    <= 1'b0;
                end else if (!counting) begin
                    counting <= 1'b1;
                    wait_cnt <= ack_delay - 3'd1;
                end else begin
                    wait_cnt <= wait_cnt - 3'd1;
                end
            end
        end
    end

endmodule

// File: verif/sprite_tests.txt
# test name, line base, attribute words of sprites 0 to 3, backdrop, late flag
# values in hex, late 1 puts column 0 inside the attribute fetch
normal_single       0000 9414F0A5 00000000 00000000 00000000 1 0
normal_8wide        0100 00000000 00000000 B000FF00 00000000 4 0
mag_even            0200 00000000 DC28A5C3 00000000 00000000 2 0
mag_odd             0300 00000000 00000000 00000000 E42AC0F1 0 0
overlap_priority    1FFC 8C50FFFF 9858FFFF E8528001 7C50FFFF E 0
clear_color_no_hit  0400 803CFFFF AC3CFFFF 00000000 00000000 3 0
late_fetch          FFFC 9414F0A5 DC28A5C3 8C50FFFF 9858FFFF 5 1
after_late          0500 BDFE8001 C5FEFFFF 00010000 00000000 6 0
four_staggered      2000 84C88888 88D0F00F CCC43C3C 90DCFFFF 7 0
empty_line          0040 00000000 00000000 00000000 00000000 8 0
mag_odd_edge        1234 F4028000 00000000 00000000 00000000 9 0

// File: verif/tb_sprite_line.sv
/*
  testbench for sprite_line_engine with tests read from verif/sprite_tests.txt
  each data line carries four attribute words, so SPRITE_COUNT must be 4
  run from the project root so the data file path resolves
*/
`timescale 1ns/1ns
`include "sprite_config.svh"

module tb_sprite_line;

    localparam int WINDOW     = 2 * (255 + 32) + 8;   // pxclk cycles checked after column 0
    localparam int WAIT_LIMIT = 200;                  // longest any single wait may run

    logic                     pxclk;
    logic                     reset;
    logic                     line_start;
    logic [`WB_ADDR_BITS-1:0] line_base;
    logic                     vdp_col0_tick;
    vdp_pkg::color_t          backdrop;
    wb_pkg::wb_rsp_t          bus_rsp;
    wb_pkg::wb_req_t          bus_req;
    vdp_pkg::color_t          pixel;
    logic                     collision;
    logic                     fetch_late;
    logic [2:0]               ack_delay;
    logic                     ld_en;
    logic [`WB_ADDR_BITS-1:0] ld_adr;
    logic [`WB_DATA_BITS-1:0] ld_dat;

    // ******************************
    // the test currently running
    // ******************************
    string                    cur_name;
    logic [`WB_ADDR_BITS-1:0] cur_base;
    vdp_pkg::sprite_attr_t    cur_attrs [`SPRITE_COUNT];
    vdp_pkg::color_t          cur_backdrop;
    logic                     cur_late;
    int                       beat_idx;     // reads acked since line_start
    int                       tests_run;

    sprite_line_engine i_dut (
        .pxclk(pxclk), .reset(reset), .line_start(line_start), .line_base(line_base),
        .vdp_col0_tick(vdp_col0_tick), .backdrop(backdrop), .bus_rsp(bus_rsp),
        .bus_req(bus_req), .pixel(pixel), .collision(collision), .fetch_late(fetch_late)
    );

    sprite_mem_model i_mem (
        .pxclk(pxclk), .reset(reset), .ack_delay(ack_delay), .ld_en(ld_en),
        .ld_adr(ld_adr), .ld_dat(ld_dat), .bus_req(bus_req), .bus_rsp(bus_rsp)
    );

    always #10 pxclk = ~pxclk;  // 20 ns pixel clock

    // a new ack delay every cycle and the slave takes it when a beat opens
    initial begin
        ack_delay = 3'd0;
        void'($urandom(83271));
        forever begin
            @(posedge pxclk);
            ack_delay <= 3'($urandom % 6);
        end
    end

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("*** FAILED ***");
        $fatal(1);
    endtask

    task automatic check_color(input string name, input string what,
                               input vdp_pkg::color_t exp, input vdp_pkg::color_t act);
        if (act !== exp) begin
            abort_run($sformatf("Mismatch in %s: %s expected %0h, actual %0h",
                                name, what, exp, act));
        end
    endtask

    task automatic check_flag(input string name, input string what, input logic exp,
                              input logic act);
        if (act !== exp) begin
            abort_run($sformatf("Mismatch in %s: %s expected %0b, actual %0b",
                                name, what, exp, act));
        end
    endtask

    task automatic check_addr(input string name, input logic [`WB_ADDR_BITS-1:0] exp,
                              input logic [`WB_ADDR_BITS-1:0] act);
        if (act !== exp) begin
            abort_run($sformatf("Mismatch in %s: adr expected %0h, actual %0h",
                                name, exp, act));
        end
    endtask

    // colour of one sprite in pxclk cycle c after the edge that took column 0
    function automatic vdp_pkg::color_t sprite_color_at(input vdp_pkg::sprite_attr_t a,
                                                        input int c);
        int start;
        int bit_i;
        start = 2 * int'(a.hpos);
        if (!a.enable || c < start) begin
            return '0;
        end
        // magnified bits move on cycles with c mod 4 equal to 3
        bit_i = a.mag ? (c / 4 - start / 4) : (c - start) / 2;
        if (bit_i > 15) begin
            return '0;
        end
        return a.pattern[15 - bit_i] ? a.fg_color : '0;
    endfunction

    task automatic wait_for_cyc(input logic level);
        int n;
        n = 0;
        while (bus_req.cyc !== level && n < WAIT_LIMIT) begin
            @(negedge pxclk);
            n++;
        end
        if (bus_req.cyc !== level) begin
            abort_run($sformatf("timeout in %s, bus cyc never went to %0b", cur_name, level));
        end
    endtask

    // pixel trails the sprites by one cycle, so cycle c shows sprite cycle c-1
    task automatic check_window();
        vdp_pkg::color_t exp_pix;
        vdp_pkg::color_t sc;
        logic            exp_coll;
        int              opaque;
        exp_coll = 1'b0;
        for (int c = 0; c < WINDOW; c++) begin
            @(negedge pxclk);
            exp_pix = cur_backdrop;
            opaque  = 0;
            for (int s = `SPRITE_COUNT - 1; s >= 0 && !cur_late; s--) begin
                sc = sprite_color_at(cur_attrs[s], c - 1);
                if (sc != '0) begin
                    exp_pix = sc;   // lower index overwrites, so it wins
                    opaque++;
                end
            end
            exp_coll = exp_coll || (opaque > 1);
            check_color(cur_name, $sformatf("pixel at cycle %0d", c), exp_pix, pixel);
            check_flag(cur_name, "collision", exp_coll, collision);
            check_flag(cur_name, "fetch_late", cur_late, fetch_late);
        end
    endtask

    task automatic run_line();
        for (int i = 0; i < `SPRITE_COUNT; i++) begin
            @(posedge pxclk);
            ld_en  <= 1'b1;
            ld_adr <= cur_base + `WB_ADDR_BITS'(i);
            ld_dat <= cur_attrs[i];
        end
        @(posedge pxclk);
        ld_en      <= 1'b0;
        line_base  <= cur_base;
        backdrop   <= cur_backdrop;
        line_start <= 1'b1;
        beat_idx = 0;
        @(posedge pxclk);
        line_start <= 1'b0;
        @(negedge pxclk);
        check_flag(cur_name, "collision after line_start", 1'b0, collision);
        check_flag(cur_name, "fetch_late after line_start", 1'b0, fetch_late);
        wait_for_cyc(1'b1);
        if (cur_late) begin
            @(posedge pxclk);
            vdp_col0_tick <= 1'b1;  // lands while the loader is still reading
            @(posedge pxclk);
            vdp_col0_tick <= 1'b0;
            check_window();
            wait_for_cyc(1'b0);
        end else begin
            wait_for_cyc(1'b0);
            repeat (10) @(posedge pxclk);
            vdp_col0_tick <= 1'b1;
            @(posedge pxclk);
            vdp_col0_tick <= 1'b0;
            check_window();
        end
        if (beat_idx != `SPRITE_COUNT) begin
            abort_run($sformatf("Mismatch in %s: bus reads expected %0d, actual %0d",
                                cur_name, `SPRITE_COUNT, beat_idx));
        end
    endtask

    // ******************************
    // bus monitor
    // ******************************
    always @(negedge pxclk) begin
        if (!reset) begin
            check_flag(cur_name, "stb without cyc", 1'b0, bus_req.stb && !bus_req.cyc);
            check_flag(cur_name, "we", 1'b0, bus_req.we && bus_req.cyc);
            if (bus_req.stb && bus_rsp.ack) begin
                check_addr(cur_name, cur_base + `WB_ADDR_BITS'(beat_idx), bus_req.adr);
                beat_idx++;
            end
        end
    end

    initial begin
        int                       fd;
        int                       n_fields;
        logic [8*160-1:0]         line_raw;
        logic [8*32-1:0]          name_raw;
        logic [`WB_ADDR_BITS-1:0] base_raw;
        logic [31:0]              w0;
        logic [31:0]              w1;
        logic [31:0]              w2;
        logic [31:0]              w3;
        logic [3:0]               bd_raw;
        logic [3:0]               late_raw;
        pxclk         = 1'b0;
        reset         = 1'b1;
        line_start    = 1'b0;
        line_base     = '0;
        vdp_col0_tick = 1'b0;
        backdrop      = 4'hf;   // pixel has to read 0 after reset even with this backdrop
        ld_en         = 1'b0;
        ld_adr        = '0;
        ld_dat        = '0;
        cur_name      = "reset";
        cur_base      = '0;
        cur_backdrop  = '0;
        cur_late      = 1'b0;
        beat_idx      = 0;
        tests_run     = 0;
        for (int i = 0; i < `SPRITE_COUNT; i++) begin
            cur_attrs[i] = '0;
        end
        repeat (5) @(posedge pxclk);
        reset <= 1'b0;
        @(negedge pxclk);
        check_color("reset", "pixel", '0, pixel);
        check_flag("reset", "collision", 1'b0, collision);
        check_flag("reset", "fetch_late", 1'b0, fetch_late);
        check_flag("reset", "cyc", 1'b0, bus_req.cyc);
        fd = $fopen("verif/sprite_tests.txt", "r");
        if (fd == 0) begin
            abort_run("could not open verif/sprite_tests.txt");
        end
        line_raw = '0;
        while ($fgets(line_raw, fd) != 0) begin
            name_raw = '0;
            // comment and blank lines give fewer fields and are skipped
            n_fields = $sscanf(line_raw, "%s %h %h %h %h %h %h %h", name_raw, base_raw,
                               w0, w1, w2, w3, bd_raw, late_raw);
            if (n_fields == 8) begin
                cur_name     = string'(name_raw);
                cur_base     = base_raw;
                cur_attrs[0] = w0;
                cur_attrs[1] = w1;
                cur_attrs[2] = w2;
                cur_attrs[3] = w3;
                cur_backdrop = bd_raw;
                cur_late     = (late_raw != 4'd0);
                run_line();
                tests_run++;
            end
            line_raw = '0;
        end
        $fclose(fd);
        if (tests_run == 0) begin
            abort_run("no test lines were read from verif/sprite_tests.txt");
        end else begin
            $display("*** PASSED ***");
            $finish;
        end
    end

endmodule
